/* common/ks10Pkg.sv */
////////////////////////////////////////
// KS10 backplane definitions
// Bus word type, address flag and field
// positions, sizes and slave latencies
////////////////////////////////////////

package ks10Pkg;

   localparam int BUS_W = 36;                 // KS10 word width

   // Bit 0 is the most significant bit, as on the real machine
   typedef logic [0:BUS_W-1] busWord;

   ////////////////////////////////////////
   // Cycle flags in the address word
   ////////////////////////////////////////

   localparam int FLAG_READ  = 3;             // Read cycle
   localparam int FLAG_WRITE = 5;             // Write cycle
   localparam int FLAG_PHYS  = 8;             // Physical address
   localparam int FLAG_IO    = 10;            // IO cycle
   localparam int FLAG_WRU   = 11;            // Who are you
   localparam int FLAG_VECT  = 12;            // Interrupt vector cycle

   ////////////////////////////////////////
   // Address fields
   ////////////////////////////////////////

   // Memory word address sits in the low bits
   localparam int MEM_ADDR_LSB = BUS_W - 1;
   localparam int MEM_ADDR_W   = 10;

   // IO device number, bits 15 to 17
   localparam int DEV_LSB = 17;
   localparam int DEV_W   = 3;

   localparam int REG_W = 3;                  // Adapter register index, low bits

   ////////////////////////////////////////
   // Sizes and latencies
   ////////////////////////////////////////

   localparam int NUM_UBA    = 4;             // Unibus adapters
   localparam int MEM_DEPTH  = 2 ** MEM_ADDR_W;
   localparam int MEM_WAIT   = 2;             // Edges from sampled req to ack
   localparam int UBA_WAIT   = 1;
   localparam int WAIT_CNT_W = 3;             // Wide enough for either wait + 1

endpackage

/* common/slaveIf.sv */
////////////////////////////////////////
// Arbiter to slave bus connection
// Level request, single cycle ack
////////////////////////////////////////

`timescale 1ns/1ps

interface slaveIf;

   import ks10Pkg::*;

   logic   req;                               // Request level from arbiter
   busWord addr;                              // Steered address word
   busWord wrData;                            // Steered write data
   logic   ack;                               // One cycle acknowledge
   busWord rdData;                            // Valid while ack is high

   // Arbiter side
   modport arbPort (
      output req,
      output addr,
      output wrData,
      input  ack,
      input  rdData
   );

   // Slave side
   // Slave decodes addr itself and ignores what is not its own
   modport slvPort (
      input  req,
      input  addr,
      input  wrData,
      output ack,
      output rdData
   );

endinterface

/* arb/busArb.sv */
////////////////////////////////////////
// KS10 bus arbiter
// Fixed priority grant, address and data
// steering, ack return, WRU default ack
////////////////////////////////////////

`timescale 1ns/1ps

module busArb (
   // CPU master
   input  logic                          cpuReq,
   input  ks10Pkg::busWord               cpuAddr,
   input  ks10Pkg::busWord               cpuWrData,
   output logic                          cpuAck,
   output ks10Pkg::busWord               cpuRdData,
   // Console master
   input  logic                          cslReq,
   input  ks10Pkg::busWord               cslAddr,
   input  ks10Pkg::busWord               cslWrData,
   output logic                          cslAck,
   output ks10Pkg::busWord               cslRdDataOut,
   // Console slave
   output logic                          cslReqOut,
   input  logic                          cslAckIn,
   input  ks10Pkg::busWord               cslRdData,
   // Unibus DMA masters
   input  logic [0:ks10Pkg::NUM_UBA-1]   ubaReq,
   input  ks10Pkg::busWord               ubaAddr [ks10Pkg::NUM_UBA],
   input  ks10Pkg::busWord               ubaWrData [ks10Pkg::NUM_UBA],
   output logic [0:ks10Pkg::NUM_UBA-1]   ubaAck,
   output ks10Pkg::busWord               ubaRdData,
   // Slaves
   slaveIf.arbPort                       memBus,
   slaveIf.arbPort                       ubaBus [ks10Pkg::NUM_UBA]
);

   import ks10Pkg::*;

   logic                 cpuGnt;              // CPU owns the bus
   logic [0:NUM_UBA-1]   ubaGnt;              // One hot DMA grant
   logic                 anyGnt;
   logic                 ubaSlvReq;           // Request to adapter registers
   busWord               selAddr;             // Granted master's address
   busWord               selWrData;
   logic [0:NUM_UBA-1]   ubaSlvAck;           // Adapter register acks
   busWord               ubaSlvData [NUM_UBA];
   logic [DEV_W-1:0]     cpuDev;              // CPU IO device number
   logic                 cpuDevUba;           // Device owned by an adapter
   logic                 wruCycle;
   logic                 rtnAck;              // Ack for the granted master
   busWord               rtnData;

   ////////////////////////////////////////
   // Grant and steering
   ////////////////////////////////////////

   // Console first, adapters 0 to 3 next, CPU last
   always_comb
   begin
      ubaGnt    = '0;
      cpuGnt    = 1'b0;
      selAddr   = '0;
      selWrData = '0;
      if (cslReq)
      begin
         selAddr   = cslAddr;
         selWrData = cslWrData;
      end
      else if (|ubaReq)
      begin
         // Walk down so the lowest adapter number wins
         for (int i = NUM_UBA - 1; i >= 0; i--)
         begin
            if (ubaReq[i])
            begin
               ubaGnt    = '0;
               ubaGnt[i] = 1'b1;
               selAddr   = ubaAddr[i];
               selWrData = ubaWrData[i];
            end
         end
      end
      else if (cpuReq)
      begin
         cpuGnt    = 1'b1;
         selAddr   = cpuAddr;
         selWrData = cpuWrData;
      end
   end

   assign anyGnt    = cslReq | (|ubaGnt) | cpuGnt;
   assign ubaSlvReq = cslReq | cpuGnt;        // DMA never reaches adapter regs

   // CPU cycle decode for the console slave and WRU
   assign cpuDev    = cpuAddr[DEV_LSB -: DEV_W];
   assign cpuDevUba = (cpuDev != '0) && (cpuDev <= DEV_W'(NUM_UBA));
   assign wruCycle  = cpuAddr[FLAG_PHYS] & cpuAddr[FLAG_IO] & cpuAddr[FLAG_WRU];

   // Console slave owns IO devices 0 and 5 to 7
   assign cslReqOut = cpuGnt & cpuAddr[FLAG_IO] & ~cpuDevUba &
                      ~cpuAddr[FLAG_WRU] & ~cpuAddr[FLAG_VECT];

   assign memBus.req    = anyGnt;             // Every master may reach memory
   assign memBus.addr   = selAddr;
   assign memBus.wrData = selWrData;

   for (genvar i = 0; i < NUM_UBA; i++)
   begin : gUbaBus
      assign ubaBus[i].req    = ubaSlvReq;
      assign ubaBus[i].addr   = selAddr;
      assign ubaBus[i].wrData = selWrData;
      assign ubaSlvAck[i]     = ubaBus[i].ack;
      assign ubaSlvData[i]    = ubaBus[i].rdData;
   end

   ////////////////////////////////////////
   // Acknowledge return
   ////////////////////////////////////////

   always_comb
   begin
      rtnAck  = 1'b0;
      rtnData = '0;
      if (memBus.ack)
      begin
         rtnAck  = 1'b1;
         rtnData = memBus.rdData;
      end
      else if (|ubaSlvAck)
      begin
         rtnAck = 1'b1;
         for (int i = NUM_UBA - 1; i >= 0; i--)
         begin
            if (ubaSlvAck[i])
               rtnData = ubaSlvData[i];       // Lowest adapter wins
         end
      end
      else if (cslReqOut & cslAckIn)
      begin
         rtnAck  = 1'b1;
         rtnData = cslRdData;
      end
      else if (cpuGnt & wruCycle)
      begin
         rtnAck  = 1'b1;                      // Nobody answered, report zero
         rtnData = '0;
      end
   end

   // Only the granted master sees the ack
   assign cslAck = cslReq & rtnAck;
   assign ubaAck = ubaGnt & {NUM_UBA{rtnAck}};
   assign cpuAck = cpuGnt & rtnAck;

   assign cpuRdData    = rtnData;
   assign cslRdDataOut = rtnData;
   assign ubaRdData    = rtnData;

endmodule

/* verilog/memCtrl.sv */
////////////////////////////////////////
// KS10 word memory
// Answers non-IO cycles after a fixed
// wait, one word per access
////////////////////////////////////////

`timescale 1ns/1ps

module memCtrl (
   input  logic      clk,
   input  logic      rstN,
   slaveIf.slvPort   bus
);

   import ks10Pkg::*;

   busWord                  memArray [MEM_DEPTH];
   logic [MEM_ADDR_W-1:0]   wordAddr;
   logic                    sel;              // Request decoded as ours
   logic [WAIT_CNT_W-1:0]   waitCnt;          // Edges sampled with sel high
   logic                    done;             // Acked, waiting for req low

   assign wordAddr = bus.addr[MEM_ADDR_LSB -: MEM_ADDR_W];

   // Memory cycle is anything that is not IO
   assign sel = bus.req & ~bus.addr[FLAG_IO] &
                (bus.addr[FLAG_READ] | bus.addr[FLAG_WRITE]);

   // Ack is combinational on sel so a dropped request never sees it
   assign bus.ack = sel & ~done & (waitCnt == WAIT_CNT_W'(MEM_WAIT + 1));

   ////////////////////////////////////////
   // Wait counter
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         waitCnt <= '0;
         done    <= 1'b0;
      end
      else if (!bus.req)
      begin
         waitCnt <= '0;                       // Restart on req low
         done    <= 1'b0;
      end
      else if (bus.ack)
      begin
         waitCnt <= '0;
         done    <= 1'b1;                     // Hold off until req drops
      end
      else if (!sel)
         waitCnt <= '0;                       // Someone else's cycle
      else if (!done)
         waitCnt <= waitCnt + 1'b1;
   end

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   // Write lands at the ack edge
   always_ff @(posedge clk)
   begin
      if (bus.ack && bus.addr[FLAG_WRITE])
         memArray[wordAddr] <= bus.wrData;
   end

   assign bus.rdData = memArray[wordAddr];    // Valid during ack

endmodule

/* verilog/ubaRegs.sv */
////////////////////////////////////////
// Unibus adapter register file
// Eight 36-bit registers answering IO
// cycles for one device number
////////////////////////////////////////

`timescale 1ns/1ps

module ubaRegs #(
   parameter int devNum = 1                   // IO device number, 1 to 4
) (
   input  logic      clk,
   input  logic      rstN,
   slaveIf.slvPort   bus
);

   import ks10Pkg::*;

   busWord                  regFile [2 ** REG_W];
   logic [REG_W-1:0]        regIdx;           // Selected register
   logic [DEV_W-1:0]        devField;
   logic                    sel;
   logic [WAIT_CNT_W-1:0]   waitCnt;
   logic                    done;

   assign regIdx   = bus.addr[BUS_W - 1 -: REG_W];
   assign devField = bus.addr[DEV_LSB -: DEV_W];

   // Our device, plain read or write, never WRU or vector
   assign sel = bus.req & bus.addr[FLAG_IO] &
                (devField == DEV_W'(devNum)) &
                ~bus.addr[FLAG_WRU] & ~bus.addr[FLAG_VECT] &
                (bus.addr[FLAG_READ] | bus.addr[FLAG_WRITE]);

   assign bus.ack = sel & ~done & (waitCnt == WAIT_CNT_W'(UBA_WAIT + 1));

   ////////////////////////////////////////
   // Wait counter
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         waitCnt <= '0;
         done    <= 1'b0;
      end
      else if (!bus.req)
      begin
         waitCnt <= '0;
         done    <= 1'b0;
      end
      else if (bus.ack)
      begin
         waitCnt <= '0;
         done    <= 1'b1;                     // One ack per request
      end
      else if (!sel)
         waitCnt <= '0;
      else if (!done)
         waitCnt <= waitCnt + 1'b1;
   end

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   // Registers come up zero
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         for (int i = 0; i < 2 ** REG_W; i++)
            regFile[i] <= '0;
      end
      else if (bus.ack && bus.addr[FLAG_WRITE])
         regFile[regIdx] <= bus.wrData;       // Update at ack edge
   end

   // Read mux, only looked at while ack is high
   assign bus.rdData = regFile[regIdx];

endmodule

/* verilog/ks10Bus.sv */
////////////////////////////////////////
// KS10 backplane top level
// Arbiter, word memory and four Unibus
// adapter register files
////////////////////////////////////////

`timescale 1ns/1ps

module ks10Bus (
   input  logic                          clk,
   input  logic                          rstN,
   // CPU
   input  logic                          cpuReq,
   input  ks10Pkg::busWord               cpuAddr,
   input  ks10Pkg::busWord               cpuWrData,
   output logic                          cpuAck,
   output ks10Pkg::busWord               cpuRdData,
   // Console master
   input  logic                          cslReq,
   input  ks10Pkg::busWord               cslAddr,
   input  ks10Pkg::busWord               cslWrData,
   output logic                          cslAck,
   output ks10Pkg::busWord               cslRdDataOut,
   // Console slave
   output logic                          cslReqOut,
   input  logic                          cslAckIn,
   input  ks10Pkg::busWord               cslRdData,
   // Unibus DMA
   input  logic [0:ks10Pkg::NUM_UBA-1]   ubaReq,
   input  ks10Pkg::busWord               uba0Addr,
   input  ks10Pkg::busWord               uba1Addr,
   input  ks10Pkg::busWord               uba2Addr,
   input  ks10Pkg::busWord               uba3Addr,
   input  ks10Pkg::busWord               uba0WrData,
   input  ks10Pkg::busWord               uba1WrData,
   input  ks10Pkg::busWord               uba2WrData,
   input  ks10Pkg::busWord               uba3WrData,
   output logic [0:ks10Pkg::NUM_UBA-1]   ubaAck,
   output ks10Pkg::busWord               ubaRdData
);

   import ks10Pkg::*;

   busWord ubaAddrArr [NUM_UBA];              // DMA addresses by adapter
   busWord ubaDataArr [NUM_UBA];

   slaveIf memIf ();                          // Arbiter to memory
   slaveIf ubaIf [NUM_UBA] ();                // Arbiter to adapter regs

   assign ubaAddrArr[0] = uba0Addr;
   assign ubaAddrArr[1] = uba1Addr;
   assign ubaAddrArr[2] = uba2Addr;
   assign ubaAddrArr[3] = uba3Addr;
   assign ubaDataArr[0] = uba0WrData;
   assign ubaDataArr[1] = uba1WrData;
   assign ubaDataArr[2] = uba2WrData;
   assign ubaDataArr[3] = uba3WrData;

   busArb u_busArb (
      .cpuReq, .cpuAddr, .cpuWrData, .cpuAck, .cpuRdData,
      .cslReq, .cslAddr, .cslWrData, .cslAck, .cslRdDataOut,
      .cslReqOut, .cslAckIn, .cslRdData,
      .ubaReq, .ubaAddr(ubaAddrArr), .ubaWrData(ubaDataArr),
      .ubaAck, .ubaRdData,
      .memBus(memIf),
      .ubaBus(ubaIf)
   );

   memCtrl u_memCtrl (.clk, .rstN, .bus(memIf));

   // Adapter n answers IO device n + 1
   for (genvar i = 0; i < NUM_UBA; i++)
   begin : gUba
      ubaRegs #(.devNum(i + 1)) u_ubaRegs (.clk, .rstN, .bus(ubaIf[i]));
   end

endmodule

/* tb/busArb_chk.sv */
////////////////////////////////////////
// Bus arbiter assertions
// Grant and acknowledge rules, bound
// into the backplane top level
////////////////////////////////////////

`timescale 1ns/1ps

module busArb_chk (
   input logic                          clk,
   input logic                          rstN,
   input logic                          cpuReq,
   input logic                          cpuAck,
   input logic                          cslReq,
   input logic                          cslAck,
   input logic [0:ks10Pkg::NUM_UBA-1]   ubaReq,
   input logic [0:ks10Pkg::NUM_UBA-1]   ubaAck,
   input logic [0:ks10Pkg::NUM_UBA]     slvReq,     // Memory, then adapters 0 to 3
   input logic [0:ks10Pkg::NUM_UBA]     slvAck
);

   // Only one master acked at a time
   ackOneHot: assert property (@(posedge clk) disable iff (!rstN)
      $onehot0({cpuAck, cslAck, ubaAck}))
      else $error("more than one master acknowledged");

   // Ack goes only to a master still requesting
   ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
      (!cpuAck || cpuReq) && (!cslAck || cslReq) && ((ubaAck & ~ubaReq) == '0))
      else $error("acknowledge without a request from that master");

   slvAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
      (slvAck & ~slvReq) == '0)
      else $error("slave ack while its req is low");

endmodule

bind ks10Bus busArb_chk u_busArbChk (
   .clk, .rstN, .cpuReq, .cpuAck, .cslReq, .cslAck, .ubaReq, .ubaAck,
   .slvReq({memIf.req, ubaIf[0].req, ubaIf[1].req, ubaIf[2].req, ubaIf[3].req}),
   .slvAck({memIf.ack, ubaIf[0].ack, ubaIf[1].ack, ubaIf[2].ack, ubaIf[3].ack})
);

/* tb/ks10Bus_tb.sv */
////////////////////////////////////////
// KS10 backplane testbench
// Directed tests of grant priority,
// memory, adapter regs and console slave
////////////////////////////////////////

`timescale 1ns/1ps

module ks10Bus_tb;

   import ks10Pkg::*;

   localparam int RESET_CYCLES    = 8;
   localparam int NUM_OPS         = 138;      // Bus operations over all tests
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_OPS * 20;
   localparam int MEM_CYCLES      = 3;        // Request to memory ack
   localparam int UBA_CYCLES      = 2;        // Request to adapter ack
   localparam int CSL_CYCLES      = 1;        // Console slave model latency
   localparam int NUM_MEM_TESTS   = 16;
   localparam int NUM_REGS        = 8;
   localparam int IO_SHIFT        = BUS_W - 1 - DEV_LSB;   // Device field, numeric
   localparam logic [31:0] LCG_SEED = 32'd56509;
   localparam logic [MEM_ADDR_W-1:0] DMA_IDX0 = 10'd1000;
   localparam logic [MEM_ADDR_W-1:0] DMA_IDX2 = 10'd1001;

   logic                 clk = 1'b0;
   logic                 rstN;
   logic                 cpuReq;
   busWord               cpuAddr;
   busWord               cpuWrData;
   logic                 cpuAck;
   busWord               cpuRdData;
   logic                 cslReq;
   busWord               cslAddr;
   busWord               cslWrData;
   logic                 cslAck;
   busWord               cslRdDataOut;
   logic                 cslReqOut;
   logic                 cslAckIn;
   busWord               cslRdData;
   logic [0:NUM_UBA-1]   ubaReq;
   busWord               ubaAddr [NUM_UBA];
   busWord               ubaWrData [NUM_UBA];
   logic [0:NUM_UBA-1]   ubaAck;
   busWord               ubaRdData;

   // Scoreboard
   busWord                  memExp [NUM_MEM_TESTS];
   logic [MEM_ADDR_W-1:0]   memIdx [NUM_MEM_TESTS];
   busWord                  regExp [NUM_UBA][NUM_REGS];
   logic [31:0]             lcgState;
   int                      checkCount;
   int                      cslHits;      // Console slave cycles answered

   always #5 clk = ~clk;                  // 10 ns clock

   ks10Bus u_ks10Bus (
      .clk, .rstN,
      .cpuReq, .cpuAddr, .cpuWrData, .cpuAck, .cpuRdData,
      .cslReq, .cslAddr, .cslWrData, .cslAck, .cslRdDataOut,
      .cslReqOut, .cslAckIn, .cslRdData,
      .ubaReq,
      .uba0Addr(ubaAddr[0]), .uba1Addr(ubaAddr[1]),
      .uba2Addr(ubaAddr[2]), .uba3Addr(ubaAddr[3]),
      .uba0WrData(ubaWrData[0]), .uba1WrData(ubaWrData[1]),
      .uba2WrData(ubaWrData[2]), .uba3WrData(ubaWrData[3]),
      .ubaAck, .ubaRdData
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lcgStep(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Two draws make one 36-bit word
   task automatic nextRand(output busWord w);
      logic [31:0] hi;
      lcgState = lcgStep(lcgState);
      hi       = lcgState;
      lcgState = lcgStep(lcgState);
      w        = {hi[31:28], lcgState};
   endtask

   function automatic busWord memAddr(input logic [MEM_ADDR_W-1:0] idx, input logic wr);
      busWord a;
      a = 36'(idx);                        // Word address in the low bits
      a[FLAG_PHYS] = 1'b1;
      if (wr)
         a[FLAG_WRITE] = 1'b1;
      else
         a[FLAG_READ] = 1'b1;
      return a;
   endfunction

   function automatic busWord ioAddr(input logic [DEV_W-1:0] dev,
                                     input logic [REG_W-1:0] regNum, input logic wr);
      busWord a;
      a = (36'(dev) << IO_SHIFT) | 36'(regNum);
      a[FLAG_PHYS] = 1'b1;
      a[FLAG_IO]   = 1'b1;
      if (wr)
         a[FLAG_WRITE] = 1'b1;
      else
         a[FLAG_READ] = 1'b1;
      return a;
   endfunction

   // Console slave data rule
   function automatic busWord cslSlaveWord(input busWord a);
      return ~a ^ 36'h0F0F0F0F0;
   endfunction

   task automatic checkEq(input string testName, input busWord expVal, input busWord actVal);
      checkCount++;
      if (expVal !== actVal)
      begin
         $display("MISMATCH %s expected %h actual %h", testName, expVal, actVal);
         $display("Simulation FAILED");
         $fatal(1, "check %s failed at %0t", testName, $time);
      end
   endtask

   // One CPU cycle, cycles counts edges until ack
   task automatic cpuAccess(input busWord addr, input busWord data,
                            output busWord rdWord, output int cycles);
      @(posedge clk);
      #1;
      cpuReq    = 1'b1;
      cpuAddr   = addr;
      cpuWrData = data;
      cycles    = 0;
      @(negedge clk);
      while (!cpuAck)
      begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end
      rdWord = cpuRdData;
      @(posedge clk);                      // Ack taken here
      #1;
      cpuReq = 1'b0;
   endtask

   // Wait for a DMA ack, only bit n may rise
   task automatic dmaWaitAck(input int n, input string testName);
      logic [0:NUM_UBA-1] expAck;
      int cycles;
      expAck    = '0;
      expAck[n] = 1'b1;
      cycles    = 0;
      @(negedge clk);
      while (ubaAck == '0)
      begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end
      checkEq(testName, 36'(expAck), 36'(ubaAck));
      checkEq(testName, 36'(MEM_CYCLES), 36'(cycles));
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic cpuMemPath();
      busWord rd;
      int cycles;
      for (int i = 0; i < NUM_MEM_TESTS; i++)
      begin
         memIdx[i] = MEM_ADDR_W'(i * 61 + 7);
         nextRand(memExp[i]);
         cpuAccess(memAddr(memIdx[i], 1'b1), memExp[i], rd, cycles);
         checkEq("cpuMemWriteCycles", 36'(MEM_CYCLES), 36'(cycles));
      end
      for (int i = 0; i < NUM_MEM_TESTS; i++)
      begin
         cpuAccess(memAddr(memIdx[i], 1'b0), '0, rd, cycles);
         checkEq("cpuMemRead", memExp[i], rd);
         checkEq("cpuMemReadCycles", 36'(MEM_CYCLES), 36'(cycles));
      end
   endtask

   task automatic ubaRegAccess();
      busWord rd;
      busWord rnd;
      int cycles;
      for (int d = 0; d < NUM_UBA; d++)
      begin
         for (int r = 0; r < NUM_REGS; r++)
         begin
            cpuAccess(ioAddr(DEV_W'(d + 1), REG_W'(r), 1'b0), '0, rd, cycles);
            checkEq("ubaResetRead", '0, rd);
            checkEq("ubaResetCycles", 36'(UBA_CYCLES), 36'(cycles));
         end
      end
      for (int d = 0; d < NUM_UBA; d++)
      begin
         for (int r = 0; r < NUM_REGS; r++)
         begin
            nextRand(rnd);
            regExp[d][r] = {4'(d + 1), 4'(r), rnd[8:35]};   // Tagged, so distinct
            cpuAccess(ioAddr(DEV_W'(d + 1), REG_W'(r), 1'b1), regExp[d][r], rd, cycles);
            checkEq("ubaWriteCycles", 36'(UBA_CYCLES), 36'(cycles));
         end
      end
      for (int d = 0; d < NUM_UBA; d++)
      begin
         for (int r = 0; r < NUM_REGS; r++)
         begin
            cpuAccess(ioAddr(DEV_W'(d + 1), REG_W'(r), 1'b0), '0, rd, cycles);
            checkEq("ubaRegRead", regExp[d][r], rd);
         end
      end
   endtask

   // Console reads adapter 1, CPU reads memory behind it
   task automatic cslPriority();
      busWord cslWord;
      busWord cpuWord;
      int cycles;
      @(posedge clk);
      #1;
      cslReq    = 1'b1;
      cslAddr   = ioAddr(3'd2, 3'd5, 1'b0);
      cslWrData = '0;
      cpuReq    = 1'b1;
      cpuAddr   = memAddr(memIdx[7], 1'b0);
      cpuWrData = '0;
      cycles    = 0;
      @(negedge clk);
      while (!cslAck)
      begin
         checkEq("cslPrioCpuHeld", '0, 36'(cpuAck));
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end
      checkEq("cslPrioCpuHeld", '0, 36'(cpuAck));
      checkEq("cslPrioCycles", 36'(UBA_CYCLES), 36'(cycles));
      cslWord = cslRdDataOut;
      @(posedge clk);
      #1;
      cslReq = 1'b0;                       // CPU takes the bus now
      cycles = 0;
      @(negedge clk);
      while (!cpuAck)
      begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end
      cpuWord = cpuRdData;
      @(posedge clk);
      #1;
      cpuReq = 1'b0;
      checkEq("cslPrioCslData", regExp[1][5], cslWord);
      checkEq("cslPrioCpuData", memExp[7], cpuWord);
      checkEq("cslPrioCpuCycles", 36'(MEM_CYCLES), 36'(cycles));
   endtask

   task automatic dmaPriority();
      busWord w0;
      busWord w2;
      busWord rd;
      int cycles;
      nextRand(w0);
      nextRand(w2);
      @(posedge clk);
      #1;
      ubaAddr[0]   = memAddr(DMA_IDX0, 1'b1);
      ubaWrData[0] = w0;
      ubaAddr[2]   = memAddr(DMA_IDX2, 1'b1);
      ubaWrData[2] = w2;
      ubaReq[0]    = 1'b1;
      ubaReq[2]    = 1'b1;
      dmaWaitAck(0, "dmaFirstAck");
      @(posedge clk);
      #1;
      // Memory holds off its next ack until req drops, adapter 2 backs off
      ubaReq[0] = 1'b0;
      ubaReq[2] = 1'b0;
      @(posedge clk);
      #1;
      ubaReq[2] = 1'b1;
      dmaWaitAck(2, "dmaSecondAck");
      @(posedge clk);
      #1;
      ubaReq[2] = 1'b0;
      // Adapter 3 reads back a word the CPU wrote earlier
      @(posedge clk);
      #1;
      ubaAddr[3] = memAddr(memIdx[3], 1'b0);
      ubaReq[3]  = 1'b1;
      dmaWaitAck(3, "dmaReadAck");
      checkEq("dmaReadData", memExp[3], ubaRdData);
      @(posedge clk);
      #1;
      ubaReq[3] = 1'b0;
      cpuAccess(memAddr(DMA_IDX0, 1'b0), '0, rd, cycles);
      checkEq("dmaWord0", w0, rd);
      cpuAccess(memAddr(DMA_IDX2, 1'b0), '0, rd, cycles);
      checkEq("dmaWord2", w2, rd);
   endtask

   // Devices 6 and 0 belong to the console
   task automatic cslSlavePath();
      busWord addr;
      busWord rd;
      int cycles;
      int hitsBefore;
      for (int k = 0; k < 2; k++)
      begin
         addr       = ioAddr((k == 0) ? 3'd6 : 3'd0, REG_W'(3 + k), 1'b0);
         hitsBefore = cslHits;
         cpuAccess(addr, '0, rd, cycles);
         checkEq("cslSlaveData", cslSlaveWord(addr), rd);
         checkEq("cslSlaveCycles", 36'(CSL_CYCLES), 36'(cycles));
         checkEq("cslSlaveHits", 36'(hitsBefore + 1), 36'(cslHits));
      end
   endtask

   task automatic wruDefault();
      busWord addr;
      busWord rd;
      int cycles;
      int hitsBefore;
      addr           = ioAddr(3'd3, 3'd0, 1'b0);
      addr[FLAG_WRU] = 1'b1;
      hitsBefore     = cslHits;
      cpuAccess(addr, 36'h777777777, rd, cycles);
      checkEq("wruData", '0, rd);
      checkEq("wruCycles", '0, 36'(cycles));      // Same cycle
      checkEq("wruNoCslSlave", 36'(hitsBefore), 36'(cslHits));
   endtask

   ////////////////////////////////////////
   // Console slave model and sequence
   ////////////////////////////////////////

   // Answers one edge after seeing cslReqOut
   initial
   begin : cslSlave
      cslAckIn  = 1'b0;
      cslRdData = '0;
      cslHits   = 0;
      forever
      begin
         @(posedge clk);
         if (cslReqOut)
         begin
            #1;
            cslRdData = cslSlaveWord(cpuAddr);
            cslAckIn  = 1'b1;
            cslHits++;
            @(posedge clk);
            #1;
            cslAckIn = 1'b0;
            @(posedge clk);
            while (cslReqOut)
               @(posedge clk);                  // Wait for request low
         end
      end
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("ERROR: watchdog expired, a bus cycle never completed");
      $display("Simulation FAILED");
      $fatal(1, "watchdog timeout at %0t", $time);
   end

   initial
   begin : mainSeq
      rstN      = 1'b0;
      cpuReq    = 1'b0;
      cpuAddr   = '0;
      cpuWrData = '0;
      cslReq    = 1'b0;
      cslAddr   = '0;
      cslWrData = '0;
      ubaReq    = '0;
      for (int i = 0; i < NUM_UBA; i++)
      begin
         ubaAddr[i]   = '0;
         ubaWrData[i] = '0;
      end
      lcgState   = LCG_SEED;
      checkCount = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstN = 1'b1;
      checkEq("resetIdle", '0, 36'({cpuAck, cslAck, ubaAck, cslReqOut}));
      cpuMemPath();
      ubaRegAccess();
      cslPriority();
      dmaPriority();
      cslSlavePath();
      wruDefault();
      if (checkCount == 0)
      begin
         $display("ERROR: no checks were run");
         $display("Simulation FAILED");
         $fatal(1, "empty run");
      end
      else
      begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

/* files.f */
common/ks10Pkg.sv
common/slaveIf.sv
arb/busArb.sv
verilog/memCtrl.sv
verilog/ubaRegs.sv
verilog/ks10Bus.sv
tb/busArb_chk.sv
tb/ks10Bus_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the KS10 backplane testbench with Verilator, run it,
# and decide pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module ks10Bus_tb --Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
   echo "Simulator exited with status $simStatus"
   exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi
